/* tb.f */
src/cu_cfg_pkg.sv
src/mem_cmd_pkg.sv
src/cu_read_arbiter.sv
src/read_command_buffer.sv
src/response_router.sv
src/cu_read_control.sv
test/cu_read_control_assertions.sv
test/cu_read_control_tb.sv

/* Makefile */
SOURCES := $(shell cat tb.f)

obj_dir/Vcu_read_control_tb: tb.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module cu_read_control_tb -f tb.f

run: obj_dir/Vcu_read_control_tb
	./obj_dir/Vcu_read_control_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "Something failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* test/cu_read_control_tb.sv */
////////////////////////////////////////
// Directed testbench for the CU read path.
// Models four CUs and the memory bus, keeps
// a scoreboard of transferred commands and
// checks the routed read responses.
////////////////////////////////////////

`timescale 1ns/1ps

module cu_read_control_tb;

	localparam int cycle_limit = 2000;

	logic                              clock;
	logic                              rstn;
	logic [cu_cfg_pkg::num_cu-1:0]     cu_request;
	mem_cmd_pkg::cu_command_t          cu_command [0:cu_cfg_pkg::num_cu-1];
	logic [cu_cfg_pkg::num_cu-1:0]     cu_ready;
	logic                              bus_alfull;
	logic                              bus_grant;
	logic                              bus_request;
	mem_cmd_pkg::mem_command_t         command_out;
	mem_cmd_pkg::mem_response_t        response_in;
	mem_cmd_pkg::mem_response_t        cu_response [0:cu_cfg_pkg::num_cu-1];

	integer seed         = 32'h265c0a05;
	int     cycle_count  = 0;
	int     value_errors = 0;
	int     event_errors = 0;

	// CU models and scoreboard
	int                                remaining [0:cu_cfg_pkg::num_cu-1];
	logic [cu_cfg_pkg::num_cu-1:0]     xfer_pending;
	logic [cu_cfg_pkg::cu_id_bits-1:0] last_xfer_id;
	logic                              grant_follow;
	logic                              grant_force;
	mem_cmd_pkg::mem_command_t         expected_q [$];
	logic [cu_cfg_pkg::cu_id_bits-1:0] out_ids [$];

	cu_read_control dut_i (
		.clock      (clock),
		.rstn       (rstn),
		.cu_request (cu_request),
		.cu_command (cu_command),
		.cu_ready   (cu_ready),
		.bus_alfull (bus_alfull),
		.bus_grant  (bus_grant),
		.bus_request(bus_request),
		.command_out(command_out),
		.response_in(response_in),
		.cu_response(cu_response)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the tests never finished", cycle_count);
			$display("Errors: %0d wrong values, %0d missing or unexpected events",
			         value_errors, event_errors);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Reporting and CU model helpers
	////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [63:0] want,
	                               input logic [63:0] got);
		$display("** Error: %s expected 0x%0h, actual 0x%0h", name, want, got);
		value_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("Problem at cycle %0d: %s", cycle_count, what);
		event_errors++;
	endtask

	function automatic int outstanding();
		int total;
		total = expected_q.size();
		for (int i = 0; i < cu_cfg_pkg::num_cu; i++) begin
			total += remaining[i];
		end
		return total;
	endfunction

	task automatic load_random_command(input int cu);
		logic [31:0] rnd;
		logic [31:0] sel;
		rnd = $random(seed);
		sel = rnd % 32'd3;
		cu_command[cu].opcode  = mem_cmd_pkg::mem_opcode_t'(sel[1:0]);
		cu_command[cu].address = $random(seed);
		cu_command[cu].tag     = rnd[15:8];
	endtask

	task automatic start_cu(input int cu, input int count);
		remaining[cu]  = count;
		cu_request[cu] = 1'b1;
		load_random_command(cu);
	endtask

	// One falling edge: check outputs, advance the CU models, drive the bus
	task automatic run_cycle();
		mem_cmd_pkg::mem_command_t want;
		@(negedge clock);
		if (bus_alfull && bus_request) report_problem("bus_request high while bus_alfull held");
		if (command_out.valid) begin
			if (bus_alfull) begin
				report_problem("command_out valid although bus_alfull blocked every grant");
			end else if (expected_q.size() == 0) begin
				report_problem("command_out valid with no command outstanding");
			end else begin
				want = expected_q.pop_front();
				out_ids.push_back(command_out.cu_id);
				if (command_out.cu_id !== want.cu_id)
					report_mismatch("command_out.cu_id", want.cu_id, command_out.cu_id);
				if (command_out.opcode !== want.opcode)
					report_mismatch("command_out.opcode", want.opcode, command_out.opcode);
				if (command_out.address !== want.address)
					report_mismatch("command_out.address", want.address, command_out.address);
				if (command_out.tag !== want.tag)
					report_mismatch("command_out.tag", want.tag, command_out.tag);
			end
		end
		for (int i = 0; i < cu_cfg_pkg::num_cu; i++) begin
			if (xfer_pending[i]) begin
				want.valid   = 1'b1;
				want.cu_id   = i[cu_cfg_pkg::cu_id_bits-1:0];
				want.opcode  = cu_command[i].opcode;
				want.address = cu_command[i].address;
				want.tag     = cu_command[i].tag;
				expected_q.push_back(want);
				last_xfer_id = i[cu_cfg_pkg::cu_id_bits-1:0];
				remaining[i]--;
				if (remaining[i] > 0) begin
					load_random_command(i);
				end else begin
					cu_request[i] = 1'b0;
				end
			end
		end
		// Request and ready both seen at the next rising edge means a transfer
		xfer_pending = cu_request & cu_ready;
		bus_grant    = grant_force || (grant_follow && bus_request);
	endtask

	task automatic wait_drained(input int limit, input string test_name);
		int waited;
		waited = 0;
		while (outstanding() != 0 && waited < limit) begin
			run_cycle();
			waited++;
		end
		if (outstanding() != 0)
			report_problem($sformatf("%s: %0d commands never reached command_out",
			                         test_name, outstanding()));
		// A few idle cycles catch duplicated commands
		repeat (3) run_cycle();
	endtask

	task automatic check_routed(input mem_cmd_pkg::mem_response_t sent);
		logic want_valid;
		for (int j = 0; j < cu_cfg_pkg::num_cu; j++) begin
			want_valid = sent.valid && (j == int'(sent.cu_id));
			if (cu_response[j].valid !== want_valid)
				report_mismatch($sformatf("cu_response[%0d].valid", j), want_valid,
				                cu_response[j].valid);
			if (want_valid) begin
				if (cu_response[j].cu_id !== sent.cu_id)
					report_mismatch("cu_response.cu_id", sent.cu_id, cu_response[j].cu_id);
				if (cu_response[j].tag !== sent.tag)
					report_mismatch("cu_response.tag", sent.tag, cu_response[j].tag);
				if (cu_response[j].status !== sent.status)
					report_mismatch("cu_response.status", sent.status, cu_response[j].status);
			end
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	// No rising edge since release, so the outputs still hold their reset values
	task automatic test_reset_outputs();
		if (cu_ready !== '0) report_mismatch("cu_ready", 64'd0, cu_ready);
		if (bus_request !== 1'b0) report_mismatch("bus_request", 64'd0, bus_request);
		if (command_out.valid !== 1'b0)
			report_mismatch("command_out.valid", 64'd0, command_out.valid);
		check_routed('0);
	endtask

	task automatic test_single_command();
		grant_follow = 1'b1;
		start_cu(2, 1);
		wait_drained(30, "single command");
	endtask

	task automatic test_round_robin();
		int                                first;
		logic [cu_cfg_pkg::cu_id_bits-1:0] want_id;
		first = (int'(last_xfer_id) + 1) % cu_cfg_pkg::num_cu;
		out_ids.delete();
		grant_follow = 1'b1;
		for (int i = 0; i < cu_cfg_pkg::num_cu; i++) begin
			start_cu(i, 4);
		end
		wait_drained(80, "round robin");
		if (out_ids.size() != 16) report_mismatch("command count", 16, out_ids.size());
		for (int k = 0; k < out_ids.size(); k++) begin
			want_id = cu_cfg_pkg::cu_id_bits'((first + k) % cu_cfg_pkg::num_cu);
			if (out_ids[k] !== want_id)
				report_mismatch("command_out.cu_id order", want_id, out_ids[k]);
		end
	endtask

	task automatic test_bus_backpressure();
		grant_follow = 1'b0;
		grant_force  = 1'b1;
		bus_alfull   = 1'b1;
		start_cu(1, 4);
		start_cu(3, 4);
		repeat (25) run_cycle();
		// Every command gathered and held in the buffer
		if (expected_q.size() != 8) report_mismatch("queued commands", 8, expected_q.size());
		bus_alfull   = 1'b0;
		grant_force  = 1'b0;
		bus_grant    = 1'b0;
		grant_follow = 1'b1;
		wait_drained(60, "bus back-pressure");
	endtask

	task automatic test_buffer_full();
		int queued;
		grant_follow = 1'b0;
		bus_grant    = 1'b0;
		for (int i = 0; i < cu_cfg_pkg::num_cu; i++) begin
			start_cu(i, 6);
		end
		repeat (30) run_cycle();
		repeat (20) begin
			run_cycle();
			if (cu_ready !== '0) report_mismatch("cu_ready while buffer full", 64'd0, cu_ready);
		end
		queued = expected_q.size();
		if (queued < cu_cfg_pkg::cmd_buffer_alfull || queued > cu_cfg_pkg::cmd_buffer_depth)
			report_problem($sformatf("%0d commands queued when cu_ready stopped", queued));
		grant_follow = 1'b1;
		wait_drained(150, "buffer full");
	endtask

	task automatic test_response_routing();
		mem_cmd_pkg::mem_response_t sent;
		logic [31:0]                rnd;
		logic [15:0]                sel;
		for (int n = 0; n < 12; n++) begin
			rnd         = $random(seed);
			sel         = rnd[31:16] % 16'd3;
			sent.valid  = 1'b1;
			sent.cu_id  = rnd[cu_cfg_pkg::cu_id_bits-1:0];
			sent.tag    = rnd[15:8];
			sent.status = mem_cmd_pkg::resp_status_t'(sel[1:0]);
			response_in = sent;
			run_cycle();
			check_routed(sent);
		end
		response_in = '0;
		run_cycle();
		check_routed('0);
	endtask

	initial begin
		clock        = 1'b0;
		rstn         = 1'b0;
		cu_request   = '0;
		bus_alfull   = 1'b0;
		bus_grant    = 1'b0;
		response_in  = '0;
		xfer_pending = '0;
		grant_follow = 1'b0;
		grant_force  = 1'b0;
		last_xfer_id = cu_cfg_pkg::last_cu_id;
		for (int i = 0; i < cu_cfg_pkg::num_cu; i++) begin
			cu_command[i] = '0;
			remaining[i]  = 0;
		end
		repeat (4) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		test_reset_outputs();
		test_single_command();
		test_round_robin();
		test_bus_backpressure();
		test_buffer_full();
		test_response_routing();

		$display("Errors: %0d wrong values, %0d missing or unexpected events",
		         value_errors, event_errors);
		if (value_errors + event_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* test/cu_read_control_assertions.sv */
////////////////////////////////////////
// Handshake rules of the CU read path,
// bound onto the top level.
////////////////////////////////////////

`timescale 1ns/1ps

module cu_read_control_assertions (
	input logic                          clock,
	input logic                          rstn,
	input logic [cu_cfg_pkg::num_cu-1:0] cu_ready,
	input logic                          almost_full,
	input logic                          bus_alfull,
	input logic                          bus_grant,
	input logic                          bus_request,
	input mem_cmd_pkg::mem_command_t     command_out
);

	ready_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_ready))
		else $error("cu_ready has more than one bit high");

	// No new ready once the buffer reports almost full
	ready_held_when_full: assert property (@(posedge clock) disable iff (!rstn)
		almost_full |=> (cu_ready == '0))
		else $error("cu_ready raised while the buffer was almost full");

	request_drops_on_alfull: assert property (@(posedge clock) disable iff (!rstn)
		bus_alfull |=> !bus_request)
		else $error("bus_request high in the cycle after bus_alfull");

	// Output only after a grant that met request and bus room
	output_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		command_out.valid |-> $past(bus_grant && bus_request && !bus_alfull))
		else $error("command_out valid without a counted grant");

endmodule

bind cu_read_control cu_read_control_assertions assertions_i (
	.clock      (clock),
	.rstn       (rstn),
	.cu_ready   (cu_ready),
	.almost_full(almost_full),
	.bus_alfull (bus_alfull),
	.bus_grant  (bus_grant),
	.bus_request(bus_request),
	.command_out(command_out)
);

/* src/cu_read_control.sv */
////////////////////////////////////////
// Read path of the vertex CU arbiter.
// CU commands are gathered round-robin,
// buffered toward the memory command bus,
// and read responses go back by CU id.
////////////////////////////////////////

`timescale 1ns/1ps

module cu_read_control (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic [cu_cfg_pkg::num_cu-1:0]      cu_request,
	input  mem_cmd_pkg::cu_command_t           cu_command [0:cu_cfg_pkg::num_cu-1],
	output logic [cu_cfg_pkg::num_cu-1:0]      cu_ready,
	input  logic                               bus_alfull,
	input  logic                               bus_grant,
	output logic                               bus_request,
	output mem_cmd_pkg::mem_command_t          command_out,
	input  mem_cmd_pkg::mem_response_t         response_in,
	output mem_cmd_pkg::mem_response_t         cu_response [0:cu_cfg_pkg::num_cu-1]
);

	mem_cmd_pkg::mem_command_t gathered;
	logic                      almost_full;

	////////////////////////////////////////
	// Command side
	////////////////////////////////////////

	cu_read_arbiter arbiter_i (
		.clock      (clock),
		.rstn       (rstn),
		.cu_request (cu_request),
		.cu_command (cu_command),
		.almost_full(almost_full),
		.cu_ready   (cu_ready),
		.gathered   (gathered)
	);

	read_command_buffer buffer_i (
		.clock      (clock),
		.rstn       (rstn),
		.gathered   (gathered),
		.almost_full(almost_full),
		.bus_alfull (bus_alfull),
		.bus_grant  (bus_grant),
		.bus_request(bus_request),
		.command_out(command_out)
	);

	////////////////////////////////////////
	// Response side
	////////////////////////////////////////

	response_router router_i (
		.clock      (clock),
		.rstn       (rstn),
		.response_in(response_in),
		.cu_response(cu_response)
	);

endmodule

/* src/response_router.sv */
////////////////////////////////////////
// Read response routing toward the CUs.
// A response is registered and shown one
// cycle later on the CU named by its id.
////////////////////////////////////////

`timescale 1ns/1ps

module response_router (
	input  logic                        clock,
	input  logic                        rstn,
	input  mem_cmd_pkg::mem_response_t  response_in,
	output mem_cmd_pkg::mem_response_t  cu_response [0:cu_cfg_pkg::num_cu-1]
);

	logic [cu_cfg_pkg::num_cu-1:0] route_valid;
	mem_cmd_pkg::mem_response_t    resp_q;

	// One valid per CU from the id decode
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			route_valid <= '0;
		end else begin
			for (int i = 0; i < cu_cfg_pkg::num_cu; i++) begin
				route_valid[i] <= response_in.valid &&
				                  (int'(response_in.cu_id) == i);
			end
		end
	end

	// Shared payload register, unchanged on its way through
	always_ff @(posedge clock) begin
		resp_q <= response_in;
	end

	generate
		for (genvar i = 0; i < cu_cfg_pkg::num_cu; i++) begin : gen_cu_out
			always_comb begin
				cu_response[i]       = resp_q;
				cu_response[i].valid = route_valid[i];
			end
		end
	endgenerate

endmodule

/* src/read_command_buffer.sv */
////////////////////////////////////////
// Burst FIFO for gathered read commands.
// Requests the memory command bus while it
// holds entries and pops one per counted
// grant onto command_out for one cycle.
////////////////////////////////////////

`timescale 1ns/1ps

module read_command_buffer (
	input  logic                       clock,
	input  logic                       rstn,
	input  mem_cmd_pkg::mem_command_t  gathered,
	output logic                       almost_full,
	input  logic                       bus_alfull,
	input  logic                       bus_grant,
	output logic                       bus_request,
	output mem_cmd_pkg::mem_command_t  command_out
);

	mem_cmd_pkg::mem_command_t fifo_mem [0:cu_cfg_pkg::cmd_buffer_depth-1];

	logic [cu_cfg_pkg::cmd_buffer_ptr_bits-1:0] wr_ptr;
	logic [cu_cfg_pkg::cmd_buffer_ptr_bits-1:0] rd_ptr;
	logic [cu_cfg_pkg::cmd_buffer_ptr_bits:0]   count;
	logic [cu_cfg_pkg::cmd_buffer_ptr_bits:0]   count_next;
	logic                                       push;
	logic                                       pop;
	logic                                       out_valid;
	mem_cmd_pkg::mem_command_t                  head_q;

	assign push = gathered.valid;

	// Grant counts only against our own request and a bus with room
	assign pop = bus_grant && bus_request && !bus_alfull;

	assign count_next  = count + push - pop;
	assign almost_full = (count >= cu_cfg_pkg::cmd_buffer_alfull);

	////////////////////////////////////////
	// Pointers, fill level, bus request
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			bus_request <= 1'b0;
			out_valid   <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count_next;
			// Uses the level after this edge so a grant never hits an empty FIFO
			bus_request <= (count_next != '0) && !bus_alfull;
			out_valid   <= pop;
		end
	end

	// Storage and output payload
	always_ff @(posedge clock) begin
		if (push) begin
			fifo_mem[wr_ptr] <= gathered;
		end
		if (pop) begin
			head_q <= fifo_mem[rd_ptr];
		end
	end

	always_comb begin
		command_out       = head_q;
		command_out.valid = out_valid;
	end

endmodule

/* src/cu_read_arbiter.sv */
////////////////////////////////////////
// Round-robin gathering of CU read commands.
// One CU gets a registered ready per cycle,
// the transferred command leaves one cycle
// later stamped with the winner's id.
////////////////////////////////////////

`timescale 1ns/1ps

module cu_read_arbiter (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic [cu_cfg_pkg::num_cu-1:0]      cu_request,
	input  mem_cmd_pkg::cu_command_t           cu_command [0:cu_cfg_pkg::num_cu-1],
	input  logic                               almost_full,
	output logic [cu_cfg_pkg::num_cu-1:0]      cu_ready,
	output mem_cmd_pkg::mem_command_t          gathered
);

	logic [cu_cfg_pkg::cu_id_bits-1:0] last_winner;
	logic [cu_cfg_pkg::cu_id_bits-1:0] grant_id;
	logic                              grant_found;
	logic [cu_cfg_pkg::num_cu-1:0]     eligible;
	logic                              transfer;
	logic                              gathered_valid;
	mem_cmd_pkg::mem_command_t         gathered_q;

	// A CU holding ready now transfers this cycle, so it sits out the next one
	assign eligible = cu_request & ~cu_ready;
	assign transfer = |(cu_request & cu_ready);

	////////////////////////////////////////
	// Round-robin search after last winner
	////////////////////////////////////////

	always_comb begin
		int cand;
		grant_found = 1'b0;
		grant_id    = last_winner;
		for (int k = 1; k <= cu_cfg_pkg::num_cu; k++) begin
			cand = (int'(last_winner) + k) % cu_cfg_pkg::num_cu;
			if (!grant_found && eligible[cand]) begin
				grant_found = 1'b1;
				grant_id    = cand[cu_cfg_pkg::cu_id_bits-1:0];
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_ready       <= '0;
			last_winner    <= cu_cfg_pkg::last_cu_id;
			gathered_valid <= 1'b0;
		end else begin
			cu_ready <= '0;
			// No new grant while the buffer is nearly full
			if (grant_found && !almost_full) begin
				cu_ready[grant_id] <= 1'b1;
				last_winner        <= grant_id;
			end
			gathered_valid <= transfer;
		end
	end

	// last_winner still names the CU whose ready is high
	always_ff @(posedge clock) begin
		if (transfer) begin
			gathered_q <= '{valid:   1'b1,
			               cu_id:   last_winner,
			               opcode:  cu_command[last_winner].opcode,
			               address: cu_command[last_winner].address,
			               tag:     cu_command[last_winner].tag};
		end
	end

	always_comb begin
		gathered       = gathered_q;
		gathered.valid = gathered_valid;
	end

endmodule

/* src/mem_cmd_pkg.sv */
////////////////////////////////////////
// Memory command and response formats.
// Opcode and status encodings plus the
// structs passed between CUs, the burst
// buffer and the memory command bus.
////////////////////////////////////////

package mem_cmd_pkg;

	localparam int addr_bits = 32;
	localparam int tag_bits  = 8;

	// Kind of read command
	typedef enum logic [1:0] {
		READ_LINE_SHARED   = 2'd0,
		READ_LINE_NO_ALLOC = 2'd1,
		READ_PREFETCH      = 2'd2
	} mem_opcode_t;

	// Outcome of a read
	typedef enum logic [1:0] {
		RESP_DONE   = 2'd0,
		RESP_FAILED = 2'd1,
		RESP_RETRY  = 2'd2
	} resp_status_t;

	// What a CU offers with its request
	typedef struct packed {
		mem_opcode_t          opcode;
		logic [addr_bits-1:0] address;
		logic [tag_bits-1:0]  tag;
	} cu_command_t;

	// Command on the memory side, stamped with the issuing CU
	typedef struct packed {
		logic                                valid;
		logic [cu_cfg_pkg::cu_id_bits-1:0]   cu_id;
		mem_opcode_t                         opcode;
		logic [addr_bits-1:0]                address;
		logic [tag_bits-1:0]                 tag;
	} mem_command_t;

	typedef struct packed {
		logic                                valid;
		logic [cu_cfg_pkg::cu_id_bits-1:0]   cu_id;
		logic [tag_bits-1:0]                 tag;
		resp_status_t                        status;
	} mem_response_t;

endpackage

/* src/cu_cfg_pkg.sv */
////////////////////////////////////////
// Sizing of the vertex CU read path.
// Holds the CU count, CU id width and burst
// buffer sizing, taken by scoped names.
////////////////////////////////////////

package cu_cfg_pkg;

	// Vertex compute units on the arbiter
	localparam int num_cu     = 4;
	localparam int cu_id_bits = 2;

	// Id of the highest CU, the round-robin start point after reset
	localparam logic [cu_id_bits-1:0] last_cu_id = cu_id_bits'(num_cu - 1);

	// Burst command FIFO
	localparam int cmd_buffer_depth    = 16;
	localparam int cmd_buffer_alfull   = 14;
	localparam int cmd_buffer_ptr_bits = $clog2(cmd_buffer_depth);

endpackage
